// File: rtl/cast_cfg.svh
/* Conversion unit configuration */
`ifndef CAST_CFG_SVH
`define CAST_CFG_SVH

// binary32 field widths
`define CAST_EXP_BITS   8
`define CAST_MAN_BITS   23
`define CAST_BIAS       127

// Integer side and internal datapath
`define CAST_INT_WIDTH  32
`define CAST_EXP_WIDTH  10  // Signed, covers -127 up to 255
`define CAST_MANT_WIDTH 32  // max(MAN_BITS+1, INT_WIDTH)

`endif

// File: rtl/cast_fmt_pkg.sv
/* Number format types */
`default_nettype none
`include "cast_cfg.svh"

package cast_fmt_pkg;

  // IEEE binary32 layout
  typedef struct packed {
    logic                      sign;
    logic [`CAST_EXP_BITS-1:0] exponent;
    logic [`CAST_MAN_BITS-1:0] mantissa;
  } fp32_t;

  // Same operand word, read as float for F2I or as integer for I2F
  typedef union packed {
    fp32_t                      fp;
    logic [`CAST_INT_WIDTH-1:0] raw;
  } operand_u;

  // Classification of a float operand
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

endpackage

`default_nettype wire

// File: rtl/cast_ctrl_pkg.sv
/* Operation and status types */
`default_nettype none

package cast_ctrl_pkg;

  typedef enum logic {
    F2I = 1'b0,  // Float to integer
    I2F = 1'b1   // Integer to float
  } cast_op_e;

  typedef enum logic {
    RNE = 1'b0,  // Nearest, ties to even
    RTZ = 1'b1   // Toward zero
  } round_mode_e;

  // IEEE exception flags
  typedef struct packed {
    logic NV;  // Invalid
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

endpackage

`default_nettype wire

// File: rtl/cast_stage_if.sv
/* Pipeline stage links */
`timescale 1ns/1ns
`default_nettype none
`include "cast_cfg.svh"

// Decode to align
interface cast_norm_if import cast_fmt_pkg::*, cast_ctrl_pkg::*; ();
  logic                              valid;
  logic                              ready;
  logic                              sign;
  logic signed [`CAST_EXP_WIDTH-1:0] exp;       // Unbiased true exponent
  logic [`CAST_MANT_WIDTH-1:0]       mant;      // Leading one at MSB
  fp_info_t                          info;
  cast_op_e                          op;
  logic                              op_mod;    // Unsigned integer when set
  round_mode_e                       rnd_mode;
  logic                              mant_zero; // Integer input was zero

  modport producer (output valid, sign, exp, mant, info, op, op_mod, rnd_mode, mant_zero,
                    input  ready);
  modport consumer (input  valid, sign, exp, mant, info, op, op_mod, rnd_mode, mant_zero,
                    output ready);
endinterface

// Align to round
interface cast_align_if import cast_fmt_pkg::*, cast_ctrl_pkg::*; ();
  logic                       valid;
  logic                       ready;
  logic                       sign;
  logic [`CAST_INT_WIDTH-1:0] value;           // Integer magnitude or packed exp/mant
  logic                       round_bit;
  logic                       sticky_bit;
  logic                       of_before_round;
  fp_info_t                   info;
  cast_op_e                   op;
  logic                       op_mod;
  round_mode_e                rnd_mode;
  logic                       mant_zero;

  modport producer (output valid, sign, value, round_bit, sticky_bit, of_before_round, info,
                    op, op_mod, rnd_mode, mant_zero, input ready);
  modport consumer (input  valid, sign, value, round_bit, sticky_bit, of_before_round, info,
                    op, op_mod, rnd_mode, mant_zero, output ready);
endinterface

`default_nettype wire

// File: rtl/cast_decode.sv
/* Stage 1, operand decode */
`timescale 1ns/1ns
`default_nettype none
`include "cast_cfg.svh"

module cast_decode
  import cast_fmt_pkg::*;
  import cast_ctrl_pkg::*;
(
  input  wire                clk_i,
  input  wire                arst_n_i,
  input  wire                in_valid_i,
  output logic               in_ready_o,
  input  wire operand_u      operand_i,
  input  wire cast_op_e      op_i,
  input  wire                op_mod_i,
  input  wire round_mode_e   rnd_mode_i,
  cast_norm_if.producer      norm_o
);

  // --------------------
  // Float view
  // --------------------
  fp32_t                             fp;
  fp_info_t                          fp_info;
  logic                              exp_zero, exp_ones, man_zero;
  logic signed [`CAST_EXP_WIDTH-1:0] fp_exp;
  logic [`CAST_MANT_WIDTH-1:0]       fp_mant;

  assign fp       = operand_i.fp;
  assign exp_zero = ~|fp.exponent;
  assign exp_ones = &fp.exponent;
  assign man_zero = ~|fp.mantissa;

  assign fp_info.is_zero       = exp_zero & man_zero;
  assign fp_info.is_subnormal  = exp_zero & ~man_zero; // Lands in sticky later, no renorm
  assign fp_info.is_inf        = exp_ones & man_zero;
  assign fp_info.is_nan        = exp_ones & ~man_zero;
  assign fp_info.is_signalling = fp_info.is_nan & ~fp.mantissa[`CAST_MAN_BITS-1]; // Quiet bit clear

  // Unbias
  assign fp_exp = $signed({{(`CAST_EXP_WIDTH-`CAST_EXP_BITS){1'b0}}, fp.exponent})
                  - `CAST_EXP_WIDTH'(`CAST_BIAS);
  // Implicit bit on top, zero pad below
  assign fp_mant = {~exp_zero, fp.mantissa, {(`CAST_MANT_WIDTH-`CAST_MAN_BITS-1){1'b0}}};

  // --------------------
  // Integer view
  // --------------------
  logic                              int_sign;
  logic [`CAST_INT_WIDTH-1:0]        int_mag;
  logic [5:0]                        lz_cnt;   // 0 to 32
  logic signed [`CAST_EXP_WIDTH-1:0] int_exp;
  logic [`CAST_MANT_WIDTH-1:0]       int_mant;

  assign int_sign = operand_i.raw[`CAST_INT_WIDTH-1] & ~op_mod_i; // Only signed ints go negative
  assign int_mag  = int_sign ? -operand_i.raw : operand_i.raw;

  // Leading-zero count, highest set bit wins
  always_comb begin : lzc
    lz_cnt = 6'(`CAST_INT_WIDTH);
    for (int i = 0; i < `CAST_INT_WIDTH; i++) begin
      if (int_mag[i]) lz_cnt = 6'(`CAST_INT_WIDTH - 1 - i);
    end
  end

  assign int_mant = int_mag << lz_cnt;  // Normalize, MSB becomes the leading one
  assign int_exp  = $signed(`CAST_EXP_WIDTH'(`CAST_INT_WIDTH - 1) - `CAST_EXP_WIDTH'(lz_cnt));

  // --------------------
  // Stage register
  // --------------------
  assign in_ready_o = norm_o.ready | ~norm_o.valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      norm_o.valid <= 1'b0;
    end else if (in_ready_o) begin
      norm_o.valid <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_ready_o && in_valid_i) begin
      norm_o.sign      <= (op_i == I2F) ? int_sign : fp.sign;
      norm_o.exp       <= (op_i == I2F) ? int_exp  : fp_exp;
      norm_o.mant      <= (op_i == I2F) ? int_mant : fp_mant;
      norm_o.info      <= fp_info;            // Only read for F2I
      norm_o.op        <= op_i;
      norm_o.op_mod    <= op_mod_i;
      norm_o.rnd_mode  <= rnd_mode_i;
      norm_o.mant_zero <= (int_mag == '0);
    end
  end

endmodule

`default_nettype wire

// File: rtl/cast_align.sv
/* Stage 2, mantissa alignment */
`timescale 1ns/1ns
`default_nettype none
`include "cast_cfg.svh"

module cast_align
  import cast_ctrl_pkg::*;
(
  input  wire             clk_i,
  input  wire             arst_n_i,
  cast_norm_if.consumer   norm_i,
  cast_align_if.producer  align_o
);

  // --------------------
  // F2I shifter
  // --------------------
  logic signed [`CAST_EXP_WIDTH-1:0] of_limit;
  logic signed [`CAST_EXP_WIDTH-1:0] shamt_full;
  logic [5:0]                        shamt;      // 0 to 33
  logic                              of_d;
  logic [2*`CAST_INT_WIDTH:0]        preshift;   // Int, round bit, sticky field
  logic [2*`CAST_INT_WIDTH:0]        shifted;

  always_comb begin : f2i_shift
    of_limit   = norm_i.op_mod ? `CAST_EXP_WIDTH'sd32 : `CAST_EXP_WIDTH'sd31; // Unsigned range one wider
    shamt_full = `CAST_EXP_WIDTH'sd31 - norm_i.exp;
    shamt      = shamt_full[5:0];
    of_d       = 1'b0;
    if (norm_i.exp >= of_limit) begin
      shamt = '0;            // Keep as is, result replaced later
      of_d  = 1'b1;
    end else if (norm_i.exp < -`CAST_EXP_WIDTH'sd1) begin
      shamt = 6'(`CAST_INT_WIDTH + 1); // Everything into sticky
    end
  end

  assign preshift = {norm_i.mant, {(`CAST_INT_WIDTH+1){1'b0}}};
  assign shifted  = preshift >> shamt;

  // --------------------
  // I2F packing
  // --------------------
  logic signed [`CAST_EXP_WIDTH-1:0] biased_exp;
  logic [`CAST_INT_WIDTH-1:0]        fp_word;

  assign biased_exp = norm_i.exp + `CAST_EXP_WIDTH'(`CAST_BIAS);
  // Exponent sits above mantissa so a rounding carry bumps it
  assign fp_word = {1'b0, biased_exp[`CAST_EXP_BITS-1:0],
                    norm_i.mant[`CAST_MANT_WIDTH-2 -: `CAST_MAN_BITS]};

  // --------------------
  // Stage register
  // --------------------
  assign norm_i.ready = align_o.ready | ~align_o.valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      align_o.valid <= 1'b0;
    end else if (norm_i.ready) begin
      align_o.valid <= norm_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (norm_i.ready && norm_i.valid) begin
      if (norm_i.op == F2I) begin
        align_o.value      <= shifted[2*`CAST_INT_WIDTH -: `CAST_INT_WIDTH];
        align_o.round_bit  <= shifted[`CAST_INT_WIDTH];
        align_o.sticky_bit <= |shifted[`CAST_INT_WIDTH-1:0];
      end else begin
        align_o.value      <= fp_word;
        align_o.round_bit  <= norm_i.mant[`CAST_MANT_WIDTH-`CAST_MAN_BITS-2]; // First dropped bit
        align_o.sticky_bit <= |norm_i.mant[`CAST_MANT_WIDTH-`CAST_MAN_BITS-3:0];
      end
      align_o.of_before_round <= of_d & (norm_i.op == F2I);
      align_o.sign            <= norm_i.sign;
      align_o.info            <= norm_i.info;
      align_o.op              <= norm_i.op;
      align_o.op_mod          <= norm_i.op_mod;
      align_o.rnd_mode        <= norm_i.rnd_mode;
      align_o.mant_zero       <= norm_i.mant_zero;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cast_round.sv
/* Stage 3, rounding and result */
`timescale 1ns/1ns
`default_nettype none
`include "cast_cfg.svh"

module cast_round
  import cast_ctrl_pkg::*;
(
  input  wire                         clk_i,
  input  wire                         arst_n_i,
  cast_align_if.consumer              align_i,
  output logic                        out_valid_o,
  input  wire                         out_ready_i,
  output logic [`CAST_INT_WIDTH-1:0]  result_o,
  output status_t                     status_o
);

  // --------------------
  // Rounding
  // --------------------
  logic                       round_up;
  logic                       inexact;
  logic [`CAST_INT_WIDTH-1:0] rounded_abs;
  logic [`CAST_INT_WIDTH-1:0] int_res;

  // Ties go to the even LSB under RNE, RTZ never increments
  assign round_up    = (align_i.rnd_mode == RNE) &
                       align_i.round_bit & (align_i.sticky_bit | align_i.value[0]);
  assign inexact     = align_i.round_bit | align_i.sticky_bit;
  assign rounded_abs = align_i.value + `CAST_INT_WIDTH'(round_up); // Carry into exp on I2F
  assign int_res     = align_i.sign ? -rounded_abs : rounded_abs;  // Two's complement

  // --------------------
  // Integer specials
  // --------------------
  logic [`CAST_INT_WIDTH-1:0] int_special;
  logic                       int_is_special;

  always_comb begin : int_special_res
    int_special = {align_i.op_mod, {(`CAST_INT_WIDTH-1){1'b1}}}; // Positive max
    if (align_i.sign && !align_i.info.is_nan) begin
      int_special = ~int_special;          // Signed min, or 0 for unsigned
    end
  end

  // NaN, inf, out of range, or negative into unsigned
  assign int_is_special = align_i.info.is_nan | align_i.info.is_inf | align_i.of_before_round |
                          (align_i.sign & align_i.op_mod & (rounded_abs != '0));

  // --------------------
  // Result select
  // --------------------
  logic [`CAST_INT_WIDTH-1:0] result_d;
  status_t                    status_d;

  always_comb begin : select
    status_d = '0;                         // DZ, OF, UF never raised
    if (align_i.op == F2I) begin
      if (int_is_special) begin
        result_d    = int_special;
        status_d.NV = 1'b1;
      end else begin
        result_d    = int_res;
        status_d.NX = inexact;
      end
    end else begin
      // Zero integer has no leading one, force +0.0
      result_d    = align_i.mant_zero ? '0
                                      : {align_i.sign, rounded_abs[`CAST_INT_WIDTH-2:0]};
      status_d.NX = inexact;
    end
  end

  // --------------------
  // Output register
  // --------------------
  assign align_i.ready = out_ready_i | ~out_valid_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (align_i.ready) begin
      out_valid_o <= align_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (align_i.ready && align_i.valid) begin
      result_o <= result_d;
      status_o <= status_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cast_unit.sv
/* Float/int conversion unit */
`timescale 1ns/1ns
`default_nettype none
`include "cast_cfg.svh"

module cast_unit
  import cast_fmt_pkg::*;
  import cast_ctrl_pkg::*;
(
  input  wire                         clk_i,
  input  wire                         arst_n_i,
  // Input side
  input  wire                         in_valid_i,
  output logic                        in_ready_o,
  input  wire operand_u               operand_i,
  input  wire cast_op_e               op_i,
  input  wire                         op_mod_i,   // Unsigned integer when set
  input  wire round_mode_e            rnd_mode_i,
  // Output side
  output logic                        out_valid_o,
  input  wire                         out_ready_i,
  output logic [`CAST_INT_WIDTH-1:0]  result_o,
  output status_t                     status_o
);

  cast_norm_if  norm_if  ();  // Decode to align
  cast_align_if align_if ();  // Align to round

  // Classify, unbias, normalize
  cast_decode u_decode (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .operand_i  (operand_i),
    .op_i       (op_i),
    .op_mod_i   (op_mod_i),
    .rnd_mode_i (rnd_mode_i),
    .norm_o     (norm_if.producer)
  );

  // Shift into place, extract round/sticky
  cast_align u_align (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .norm_i   (norm_if.consumer),
    .align_o  (align_if.producer)
  );

  // Round, specials, flags
  cast_round u_round (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .align_i     (align_if.consumer),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_cast_unit.sv
/* Conversion unit testbench */
`timescale 1ns/1ns
`default_nettype none
`include "cast_cfg.svh"

module tb_cast_unit
  import cast_fmt_pkg::*;
  import cast_ctrl_pkg::*;
();

  localparam int MAX_VEC   = 64;
  localparam int VEC_WORDS = 6;  // op, op_mod, rnd_mode, operand, result, status
  localparam int LATENCY   = 3;

  // --------------------
  // DUT signals
  // --------------------
  logic                       clk = 1'b0;
  logic                       arst_n;
  logic                       in_valid;
  logic                       in_ready;
  operand_u                   operand;
  cast_op_e                   op;
  logic                       op_mod;
  round_mode_e                rnd_mode;
  logic                       out_valid;
  logic                       out_ready;
  logic [`CAST_INT_WIDTH-1:0] result;
  status_t                    status;

  // Scoreboard state
  logic [31:0]                stim_mem [0:MAX_VEC*VEC_WORDS-1];
  logic [`CAST_INT_WIDTH-1:0] exp_result_q [$];
  status_t                    exp_status_q [$];
  int                         accept_cycle_q [$];
  int                         vec_idx_q [$];
  int                         n_vec;
  int                         n_checked;
  int                         value_errors;
  int                         other_errors;
  int                         cycle;
  int                         timeout_limit;
  logic [31:0]                lfsr_state;
  logic                       stall_en;    // Random back-pressure phase
  logic                       ready_draw;

  cast_unit DUT (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .operand_i   (operand),
    .op_i        (op),
    .op_mod_i    (op_mod),
    .rnd_mode_i  (rnd_mode),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result),
    .status_o    (status)
  );

  always #4 clk = ~clk;  // 8 ns period

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out_bit;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_result(input int idx, input logic [`CAST_INT_WIDTH-1:0] expected,
                              input logic [`CAST_INT_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED result_o: vector %0d expected %08h got %08h", idx, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_status(input int idx, input status_t expected, input status_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED status_o: vector %0d expected %02h got %02h", idx, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %0h got %0h", name, expected, actual);
      value_errors++;
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic load_vectors();
    for (int i = 0; i < MAX_VEC * VEC_WORDS; i++) begin
      stim_mem[i] = 32'hffff_0000 | 32'(i);  // Marks words the file leaves empty
    end
    $readmemh("testbench/cast_stim.txt", stim_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && stim_mem[n_vec * VEC_WORDS] <= 32'd1) begin
      n_vec++;
    end
  endtask

  task automatic send_vector(input int idx, input logic gaps);
    int base;
    base = idx * VEC_WORDS;
    @(posedge clk);                          // Previous item is taken on this edge
    while (gaps && lfsr_bit()) begin
      in_valid <= 1'b0;                      // Idle cycle
      @(posedge clk);
    end
    in_valid    <= 1'b1;
    op          <= cast_op_e'(stim_mem[base][0]);
    op_mod      <= stim_mem[base + 1][0];
    rnd_mode    <= round_mode_e'(stim_mem[base + 2][0]);
    operand.raw <= stim_mem[base + 3];
    @(negedge clk);
    while (!in_ready) @(negedge clk);        // Held stable through the stall
    // Accepted on the coming edge
    exp_result_q.push_back(stim_mem[base + 4]);
    exp_status_q.push_back(status_t'(stim_mem[base + 5][4:0]));
    accept_cycle_q.push_back(cycle);
    vec_idx_q.push_back(idx);
  endtask

  task automatic drain_pipeline();
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_result_q.size() != 0) @(negedge clk);
    repeat (4) @(posedge clk);               // Room for stray outputs
  endtask

  // Output back-pressure drawn at negedge and applied at posedge
  always begin : ready_drive
    @(negedge clk);
    ready_draw = stall_en ? lfsr_bit() : 1'b1;
    @(posedge clk);
    out_ready <= ready_draw;
  end

  // --------------------
  // Output monitor
  // --------------------
  always @(negedge clk) begin : monitor
    int idx;
    int acc;
    if (arst_n && out_valid && out_ready) begin
      if (exp_result_q.size() == 0) begin
        $display("Output transfer at cycle %0d with no input outstanding", cycle);
        other_errors++;
      end else begin
        idx = vec_idx_q.pop_front();
        acc = accept_cycle_q.pop_front();
        check_result(idx, exp_result_q.pop_front(), result);
        check_status(idx, exp_status_q.pop_front(), status);
        if (!stall_en && (cycle - acc != LATENCY)) begin
          $display("Vector %0d came out %0d cycles after acceptance", idx, cycle - acc);
          other_errors++;
        end
        n_checked++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle <= cycle + 1;
    if (cycle >= timeout_limit) begin
      $display("Run timed out after %0d cycles with %0d results outstanding",
               cycle, exp_result_q.size());
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin : main
    lfsr_state   = 32'h53e7_2621;
    stall_en     = 1'b0;
    n_checked    = 0;
    value_errors = 0;
    other_errors = 0;
    cycle        = 0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    operand      = '0;
    op           = F2I;
    op_mod       = 1'b0;
    rnd_mode     = RNE;
    out_ready    = 1'b1;
    load_vectors();
    timeout_limit = 40 * 2 * n_vec + 100;  // Two passes over the vectors
    if (n_vec == 0) begin
      $display("No vectors found in the stimulus file");
      other_errors++;
    end
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_bit("out_valid_o", 1'b0, out_valid);
    check_bit("in_ready_o", 1'b1, in_ready);
    // Back to back with no stalls and fixed latency
    for (int i = 0; i < n_vec; i++) begin
      send_vector(i, 1'b0);
    end
    drain_pipeline();
    stall_en = 1'b1;
    // Random gaps and random stalls
    for (int i = 0; i < n_vec; i++) begin
      send_vector(i, 1'b1);
    end
    drain_pipeline();
    $display("Errors: %0d value mismatches, %0d other, %0d results checked",
             value_errors, other_errors, n_checked);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/cast_stim.txt
// op op_mod rnd_mode operand expected_result expected_status, all hex
// op 0 F2I 1 I2F, op_mod 1 unsigned, rnd_mode 0 RNE 1 RTZ, status NV 10 NX 01
0 0 0 3F800000 00000001 00
0 0 0 BF800000 FFFFFFFF 00
0 0 0 00000000 00000000 00
0 1 0 80000000 00000000 00
0 1 0 42C80000 00000064 00
0 1 1 4F000000 80000000 00
0 0 0 40200000 00000002 01
0 0 0 40600000 00000004 01
0 0 0 C0300000 FFFFFFFD 01
0 0 1 C0300000 FFFFFFFE 01
0 0 0 3F000000 00000000 01
0 1 0 3F400000 00000001 01
0 0 0 7FC00000 7FFFFFFF 10
0 1 0 FF800001 FFFFFFFF 10
0 0 0 7F800000 7FFFFFFF 10
0 0 0 FF800000 80000000 10
0 1 1 FF800000 00000000 10
0 0 1 4F000000 7FFFFFFF 10
0 1 0 4F800000 FFFFFFFF 10
0 1 0 BF800000 00000000 10
0 1 0 BF400000 00000000 10
0 1 0 BF000000 00000000 01
0 0 0 00000001 00000000 01
0 1 1 807FFFFF 00000000 01
1 0 0 00000001 3F800000 00
1 0 0 FFFFFFFB C0A00000 00
1 0 0 00000000 00000000 00
1 0 0 80000000 CF000000 00
1 1 0 80000000 4F000000 00
1 1 0 000000FF 437F0000 00
1 1 0 01000001 4B800000 01
1 1 0 01000003 4B800002 01
1 0 0 7FFFFFFF 4F000000 01
1 0 1 FEFFFFFF CB800000 01
1 0 0 12345678 4D91A2B4 01
1 0 1 12345678 4D91A2B3 01

// File: filelist.f
+incdir+rtl
rtl/cast_fmt_pkg.sv
rtl/cast_ctrl_pkg.sv
rtl/cast_stage_if.sv
rtl/cast_decode.sv
rtl/cast_align.sv
rtl/cast_round.sv
rtl/cast_unit.sv
testbench/tb_cast_unit.sv

// File: Makefile
# Verilator flow for the float/int conversion unit

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_cast_unit
LINT_TOP  ?= cast_unit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
